// ==== checksum_gen.f ====
logic/chk_pkg.sv
logic/col_checksum_a.sv
logic/row_checksum_b.sv
logic/mode_ctrl.sv
logic/checksum_gen.sv
dv/checksum_gen_tb.sv

// ==== dv/checksum_gen_tb.sv ====
module checksum_gen_tb;

    import chk_pkg::*;

    localparam int N         = 4;            // small matrices keep the run short
    localparam int W         = DEF_DATA_W;
    localparam int N_TESTS   = 6;
    localparam int WD_CYCLES = N_TESTS * (N + 2) * (N + 8) + 100;

    typedef logic [N*W-1:0] row_t;

    logic                 clk;
    logic                 arst_n;
    row_t                 data_in;
    logic [$clog2(N)-1:0] a_sel;
    mode_e                mode;
    logic                 gen_en;
    logic                 fetch_a;
    logic                 fetch_b;
    logic [W-1:0]         data_ac_out;
    logic [(N+1)*W-1:0]   data_br_out;
    logic                 data_br_ready;
    logic                 fetch_a_ready;
    logic                 fetch_b_ready;
    full_t                full;

    integer       seed;
    int           cyc = 0;
    int           errs = 0;
    int           checks = 0;
    int           test_num = 0;
    int           test_errs;
    string        test_name;
    int           a_ready_cnt = 0;
    int           b_ready_cnt = 0;
    int           a_fetch_cyc;
    int           b_fetch_cyc;
    logic         a_valid = 1'b0;          // data_ac_out expected to hold exp_a
    logic [W-1:0] exp_a [N];
    row_t         a_hist [64];             // A rows since last entry into detect
    int           a_cnt;
    logic [W-1:0] exp_b_row [N];
    logic [W-1:0] exp_b_sum;
    int           exp_b_lat;
    logic         exp_b_last;
    logic [W-1:0] b_sum_ref [N];           // row sums of the first B pass
    int           b_idx;                   // runs 1..N and is 0 after a mode change
    logic         b_built;

    checksum_gen #(
        .N_DIM  (N),
        .DATA_W (W)
    ) i_checksum_gen (
        .clk           (clk),
        .arst_n        (arst_n),
        .data_in       (data_in),
        .a_sel         (a_sel),
        .mode          (mode),
        .gen_en        (gen_en),
        .fetch_a       (fetch_a),
        .fetch_b       (fetch_b),
        .data_ac_out   (data_ac_out),
        .data_br_out   (data_br_out),
        .data_br_ready (data_br_ready),
        .fetch_a_ready (fetch_a_ready),
        .fetch_b_ready (fetch_b_ready),
        .full          (full)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("timeout: run still busy after %0d cycles", WD_CYCLES);
        $display("Test failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////
    function automatic logic [W-1:0] col_ref(input int c);
        logic [W-1:0] s;
        s = '0;
        for (int r = 0; r < a_cnt; r++) begin
            s = s + a_hist[r][c*W +: W];   // wraps at W bits
        end
        return s;
    endfunction

    function automatic logic [W-1:0] row_ref(input row_t row);
        logic [W-1:0] s;
        s = '0;
        for (int j = 0; j < N; j++) begin
            s = s + row[j*W +: W];
        end
        return s;
    endfunction

    // bit 0 detect, bit 1 corr pass 1, bit 2 corr pass 2
    function automatic full_t full_code(input mode_e m);
        case (m)
            MODE_DETECT: return 3'b001;
            MODE_CORR1:  return 3'b010;
            MODE_CORR2:  return 3'b100;
            default:     return 3'b000;
        endcase
    endfunction

    task automatic check_val(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errs++;
            $display("FAILED %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // compare process samples outputs mid-cycle
    //////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (arst_n) begin
            if (gen_en && fetch_a) a_fetch_cyc = cyc;
            if (gen_en && fetch_b) b_fetch_cyc = cyc;
            if (fetch_a_ready) begin
                a_ready_cnt++;
                check_val("A latency", cyc - a_fetch_cyc - 1, 2);
                a_valid = 1'b1;
            end
            if (a_valid) begin
                check_val($sformatf("A element %0d", a_sel), data_ac_out, exp_a[a_sel]);
            end
            if (data_br_ready) begin
                b_ready_cnt++;
                check_val("B latency", cyc - b_fetch_cyc - 1, exp_b_lat);
                for (int j = 0; j < N; j++) begin
                    check_val($sformatf("B element %0d", j), data_br_out[j*W +: W],
                              exp_b_row[j]);
                end
                check_val("B row sum", data_br_out[N*W +: W], exp_b_sum);
            end
            if (data_br_ready || fetch_b_ready) begin
                check_val("fetch_b_ready", fetch_b_ready, data_br_ready && exp_b_last);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus tasks
    //////////////////////////////////////////////////////////////////////
    task automatic rand_row(output row_t row);
        for (int i = 0; i < N; i++) begin
            row[i*W +: W] = $random(seed);
        end
    endtask

    task automatic set_mode(input mode_e m);
        @(posedge clk);
        mode <= m;
        a_valid = 1'b0;                 // restart moves the A select
        b_idx   = 0;
        if (m == MODE_DETECT) begin
            a_cnt   = 0;                // new matrices
            b_built = 1'b0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_val("full after mode change", full, 3'b000);
    endtask

    task automatic fetch_a_row(input logic is_chk);
        row_t row;
        int   target;
        rand_row(row);                  // ignored by the DUT on checksum fetch
        target = a_ready_cnt + 1;
        @(posedge clk);
        a_valid = 1'b0;
        if (!is_chk) begin
            a_hist[a_cnt] = row;
            a_cnt++;
        end
        for (int c = 0; c < N; c++) begin
            exp_a[c] = is_chk ? col_ref(c) : row[c*W +: W];
        end
        data_in <= row;
        fetch_a <= 1'b1;
        @(posedge clk);
        fetch_a <= 1'b0;
        while (a_ready_cnt < target) @(posedge clk);
        // sweep the select so every element gets checked
        for (int k = 0; k < N; k++) begin
            @(posedge clk);
            a_sel <= $bits(a_sel)'(k);
        end
        @(negedge clk);
        check_val("full", full, is_chk ? full_code(mode) : 3'b000);
    endtask

    task automatic fetch_b_row;
        row_t row;
        int   target;
        rand_row(row);
        target = b_ready_cnt + 1;
        b_idx  = (b_idx == N) ? 1 : b_idx + 1;
        for (int j = 0; j < N; j++) begin
            exp_b_row[j] = row[j*W +: W];
        end
        if (b_built) begin
            exp_b_sum = b_sum_ref[b_idx-1];     // stored sum of the first pass
            exp_b_lat = 1;
        end else begin
            exp_b_sum = row_ref(row);
            b_sum_ref[b_idx-1] = exp_b_sum;
            exp_b_lat = N + 1;                  // serial add of one element per cycle
        end
        exp_b_last = (b_idx == N);
        @(posedge clk);
        data_in <= row;
        fetch_b <= 1'b1;
        @(posedge clk);
        fetch_b <= 1'b0;
        while (b_ready_cnt < target) @(posedge clk);
        if (!b_built && b_idx == N) b_built = 1'b1;
    endtask

    // strobes with gen_en low must leave everything still
    task automatic hold_check;
        logic [W-1:0]       ac;
        logic [(N+1)*W-1:0] br;
        full_t              f;
        int                 na;
        int                 nb;
        row_t               row;
        rand_row(row);
        @(negedge clk);
        ac = data_ac_out;
        br = data_br_out;
        f  = full;
        na = a_ready_cnt;
        nb = b_ready_cnt;
        @(posedge clk);
        gen_en <= 1'b0;
        @(posedge clk);
        data_in <= row;
        fetch_a <= 1'b1;
        fetch_b <= 1'b1;
        @(posedge clk);
        fetch_a <= 1'b0;
        fetch_b <= 1'b0;
        repeat (N + 4) @(posedge clk);
        @(negedge clk);
        check_val("A ready count", a_ready_cnt, na);
        check_val("B ready count", b_ready_cnt, nb);
        check_val("data_ac_out held", data_ac_out, ac);
        for (int j = 0; j <= N; j++) begin
            check_val($sformatf("data_br_out element %0d held", j), data_br_out[j*W +: W],
                      br[j*W +: W]);
        end
        check_val("full held", full, f);
        @(posedge clk);
        gen_en <= 1'b1;
    endtask

    task automatic start_test(input string name);
        test_num++;
        test_name = name;
        test_errs = errs;
    endtask

    task automatic finish_test;
        $display("[%0d] %s: %0d mismatches", test_num, test_name, errs - test_errs);
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        seed    = 32'h89d0;
        arst_n  = 1'b0;
        data_in = '0;
        a_sel   = '0;
        mode    = MODE_IDLE;
        gen_en  = 1'b1;
        fetch_a = 1'b0;
        fetch_b = 1'b0;
        a_cnt   = 0;
        b_idx   = 0;
        b_built = 1'b0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        start_test("detect mode, A rows then checksum row");
        @(negedge clk);
        check_val("full after reset", full, 3'b000);
        set_mode(MODE_DETECT);
        repeat (N) fetch_a_row(1'b0);
        fetch_a_row(1'b1);
        finish_test();

        start_test("first B pass, serial row sums");
        repeat (N) fetch_b_row();
        finish_test();

        start_test("second B pass, stored sums");
        repeat (N) fetch_b_row();
        finish_test();

        start_test("correction passes keep the checksums");
        set_mode(MODE_CORR1);
        repeat (N) fetch_a_row(1'b0);
        fetch_a_row(1'b1);
        set_mode(MODE_CORR2);
        repeat (N) fetch_a_row(1'b0);
        fetch_a_row(1'b1);
        finish_test();

        start_test("gen_en low blocks strobes");
        hold_check();
        finish_test();

        start_test("return to detect clears sums");
        set_mode(MODE_DETECT);
        repeat (N) fetch_a_row(1'b0);
        fetch_a_row(1'b1);
        fetch_b_row();
        finish_test();

        $display("%0d tests run, %0d checks, %0d errors", test_num, checks, errs);
        if (errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== logic/checksum_gen.sv ====
module checksum_gen #(
    parameter int N_DIM  = chk_pkg::DEF_N_DIM,
    parameter int DATA_W = chk_pkg::DEF_DATA_W
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [N_DIM*DATA_W-1:0]     data_in,
    input  logic [$clog2(N_DIM)-1:0]    a_sel,
    input  chk_pkg::mode_e              mode,
    input  logic                        gen_en,
    input  logic                        fetch_a,
    input  logic                        fetch_b,
    output logic [DATA_W-1:0]           data_ac_out,
    output logic [(N_DIM+1)*DATA_W-1:0] data_br_out,
    output logic                        data_br_ready,
    output logic                        fetch_a_ready,
    output logic                        fetch_b_ready,
    output chk_pkg::full_t              full
);

    import chk_pkg::*;

    ctrl_t  ctrl;       // restart and clear, to both units
    a_evt_t a_evt;      // A completion, to the mode controller

    //////////////////////////////////////////////////////////////////////
    // column checksums of A
    //////////////////////////////////////////////////////////////////////
    col_checksum_a #(
        .N_DIM  (N_DIM),
        .DATA_W (DATA_W)
    ) i_col_checksum_a (
        .clk           (clk),
        .arst_n        (arst_n),
        .gen_en        (gen_en),
        .fetch_a       (fetch_a),
        .data_in       (data_in),
        .a_sel         (a_sel),
        .ctrl          (ctrl),
        .data_ac_out   (data_ac_out),
        .fetch_a_ready (fetch_a_ready),
        .a_evt         (a_evt)
    );

    // row checksums of B, row goes straight out
    row_checksum_b #(
        .N_DIM  (N_DIM),
        .DATA_W (DATA_W)
    ) i_row_checksum_b (
        .clk           (clk),
        .arst_n        (arst_n),
        .gen_en        (gen_en),
        .fetch_b       (fetch_b),
        .data_in       (data_in),
        .ctrl          (ctrl),
        .data_br_out   (data_br_out),
        .data_br_ready (data_br_ready),
        .fetch_b_ready (fetch_b_ready)
    );

    mode_ctrl #(
        .N_DIM  (N_DIM),
        .DATA_W (DATA_W)
    ) i_mode_ctrl (
        .clk    (clk),
        .arst_n (arst_n),
        .mode   (mode),
        .a_evt  (a_evt),
        .ctrl   (ctrl),
        .full   (full)
    );

endmodule

// ==== logic/mode_ctrl.sv ====
module mode_ctrl #(
    parameter int N_DIM  = chk_pkg::DEF_N_DIM,
    parameter int DATA_W = chk_pkg::DEF_DATA_W
) (
    input  logic            clk,
    input  logic            arst_n,
    input  chk_pkg::mode_e  mode,
    input  chk_pkg::a_evt_t a_evt,
    output chk_pkg::ctrl_t  ctrl,
    output chk_pkg::full_t  full
);

    import chk_pkg::*;

    mode_e mode_q;      // mode seen at the last edge
    logic  mode_chg;
    full_t pass_code;   // one-hot flag of the running pass

    // sizes the units cannot work with
    if (N_DIM < 2 || DATA_W < 1) begin : g_param_chk
        $error("checksum_gen needs N_DIM >= 2 and DATA_W >= 1");
    end

    assign mode_chg = (mode != mode_q);

    always_comb begin
        case (mode_q)
            MODE_DETECT: pass_code = FULL_DETECT;
            MODE_CORR1:  pass_code = FULL_CORR1;
            MODE_CORR2:  pass_code = FULL_CORR2;
            default:     pass_code = '0;           // idle has no pass
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // mode tracking, commands and full flag
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode_q <= MODE_IDLE;
            ctrl   <= '0;
            full   <= '0;
        end else begin
            mode_q            <= mode;
            ctrl.restart_rows <= mode_chg;                             // any change
            ctrl.clear_sums   <= mode_chg && (mode == MODE_DETECT);    // new matrices

            if (mode_chg) begin
                full <= '0;
            end else if (a_evt.row_done) begin
                full <= a_evt.chk_row ? pass_code : '0;   // set on the checksum fetch
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////
    a_full_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(full))
        else $error("full is not one-hot");

endmodule

// ==== logic/row_checksum_b.sv ====
module row_checksum_b #(
    parameter int N_DIM  = chk_pkg::DEF_N_DIM,
    parameter int DATA_W = chk_pkg::DEF_DATA_W
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        gen_en,
    input  logic                        fetch_b,
    input  logic [N_DIM*DATA_W-1:0]     data_in,
    input  chk_pkg::ctrl_t              ctrl,
    output logic [(N_DIM+1)*DATA_W-1:0] data_br_out,
    output logic                        data_br_ready,
    output logic                        fetch_b_ready
);

    localparam int RIDX_W = $clog2(N_DIM + 1);
    localparam int SIDX_W = $clog2(N_DIM);
    localparam logic [RIDX_W-1:0] CNT_N   = RIDX_W'(N_DIM);
    localparam logic [RIDX_W-1:0] ROW_ONE = RIDX_W'(1);

    logic [DATA_W-1:0] row_q   [N_DIM];    // captured B row
    logic [DATA_W-1:0] sum_mem [N_DIM];    // stored row sums, one per row
    logic [DATA_W-1:0] acc;                // serial adder
    logic [RIDX_W-1:0] row_idx;            // 1..N_DIM, 0 right after restart
    logic [RIDX_W-1:0] elem_cnt;           // element being added
    logic [SIDX_W-1:0] sum_idx;
    logic              busy;               // serial addition running
    logic              hit_q;              // row served from stored sums
    logic              built;              // all row sums stored
    logic              accept;
    logic              done;

    //////////////////////////////////////////////////////////////////////
    // fetch and serial sum control
    //////////////////////////////////////////////////////////////////////
    assign accept = gen_en && fetch_b && !busy && !hit_q;
    assign done   = busy && (elem_cnt == CNT_N);   // store phase, edge t+N_DIM+1

    // row_idx is one-based, storage is zero-based
    assign sum_idx = (row_idx == '0) ? '0 : SIDX_W'(row_idx - 1'b1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            row_idx       <= '0;
            elem_cnt      <= '0;
            busy          <= 1'b0;
            hit_q         <= 1'b0;
            built         <= 1'b0;
            data_br_ready <= 1'b0;
            fetch_b_ready <= 1'b0;
        end else begin
            data_br_ready <= done || hit_q;
            fetch_b_ready <= (done || hit_q) && (row_idx == CNT_N);  // last row
            hit_q         <= accept && built;                        // ready at t+1

            if (ctrl.restart_rows) begin
                row_idx <= '0;
            end else if (accept) begin
                row_idx <= (row_idx == CNT_N) ? ROW_ONE : row_idx + 1'b1;
            end

            if (accept && !built) begin
                busy     <= 1'b1;
                elem_cnt <= '0;
            end else if (done) begin
                busy     <= 1'b0;
            end else if (busy) begin
                elem_cnt <= elem_cnt + 1'b1;
            end

            // built after the last row of the first pass
            if (ctrl.clear_sums) begin
                built <= 1'b0;
            end else if (done && (row_idx == CNT_N)) begin
                built <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int i = 0; i < N_DIM; i++) begin
                row_q[i] <= data_in[i*DATA_W +: DATA_W];
            end
        end
    end

    // one element per cycle, edges t+1..t+N_DIM
    always_ff @(posedge clk) begin
        if (accept) begin
            acc <= '0;
        end else if (busy && !done) begin
            acc <= acc + row_q[SIDX_W'(elem_cnt)];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < N_DIM; i++) begin
                sum_mem[i] <= '0;
            end
        end else if (ctrl.clear_sums) begin
            for (int i = 0; i < N_DIM; i++) begin
                sum_mem[i] <= '0;
            end
        end else if (done) begin
            sum_mem[sum_idx] <= acc;
        end
    end

    // extended row, sum of the current row in the top column
    always_comb begin
        for (int j = 0; j < N_DIM; j++) begin
            data_br_out[j*DATA_W +: DATA_W] = row_q[j];
        end
        data_br_out[N_DIM*DATA_W +: DATA_W] = sum_mem[sum_idx];
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////
    a_fetch_busy: assert property (@(posedge clk) disable iff (!arst_n)
        (gen_en && fetch_b) |-> !(busy || hit_q))
        else $error("fetch_b while a B row is still being summed");

endmodule

// ==== logic/col_checksum_a.sv ====
module col_checksum_a #(
    parameter int N_DIM  = chk_pkg::DEF_N_DIM,
    parameter int DATA_W = chk_pkg::DEF_DATA_W
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     gen_en,
    input  logic                     fetch_a,
    input  logic [N_DIM*DATA_W-1:0]  data_in,
    input  logic [$clog2(N_DIM)-1:0] a_sel,
    input  chk_pkg::ctrl_t           ctrl,
    output logic [DATA_W-1:0]        data_ac_out,
    output logic                     fetch_a_ready,
    output chk_pkg::a_evt_t          a_evt
);

    // row count runs 0..N_DIM+1, N_DIM+1 means checksum row is out
    localparam int CNT_W = $clog2(N_DIM + 2);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(N_DIM);
    localparam logic [CNT_W-1:0] CNT_CHK  = CNT_W'(N_DIM + 1);

    logic [DATA_W-1:0] row_q   [N_DIM];    // captured A row
    logic [DATA_W-1:0] col_sum [N_DIM];    // running column checksums
    logic [CNT_W-1:0]  row_cnt;
    logic              s1_vld;             // stage 1, row captured
    logic              s1_add;             // stage 1 carries data to add
    logic              s2_vld;             // stage 2, addition done
    logic              accept;
    logic              chk_sel;

    //////////////////////////////////////////////////////////////////////
    // fetch acceptance and pipeline control
    //////////////////////////////////////////////////////////////////////
    // strobe dropped while gen_en low or a fetch is in flight
    assign accept  = gen_en && fetch_a && !s1_vld && !s2_vld;
    assign chk_sel = (row_cnt == CNT_CHK);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            row_cnt       <= '0;
            s1_vld        <= 1'b0;
            s1_add        <= 1'b0;
            s2_vld        <= 1'b0;
            fetch_a_ready <= 1'b0;
        end else begin
            s1_vld        <= accept;
            s1_add        <= accept && (row_cnt < CNT_LAST);  // data rows only
            s2_vld        <= s1_vld;
            fetch_a_ready <= s2_vld;                          // edge t+2

            if (ctrl.restart_rows) begin
                row_cnt <= '0;              // new pass starts at row 0
            end else if (accept) begin
                if (row_cnt < CNT_LAST) begin
                    row_cnt <= row_cnt + 1'b1;
                end else begin
                    row_cnt <= CNT_CHK;     // parks on the checksum row
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // row capture and column accumulation
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (accept && (row_cnt < CNT_LAST)) begin
            for (int i = 0; i < N_DIM; i++) begin
                row_q[i] <= data_in[i*DATA_W +: DATA_W];
            end
        end
    end

    // one cycle behind the capture, wraps at DATA_W
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < N_DIM; i++) begin
                col_sum[i] <= '0;
            end
        end else if (ctrl.clear_sums) begin
            for (int i = 0; i < N_DIM; i++) begin
                col_sum[i] <= '0;
            end
        end else if (s1_add) begin
            for (int i = 0; i < N_DIM; i++) begin
                col_sum[i] <= col_sum[i] + row_q[i];
            end
        end
    end

    // element select, checksum row once the count has passed N_DIM
    assign data_ac_out = chk_sel ? col_sum[a_sel] : row_q[a_sel];

    assign a_evt = '{row_done: fetch_a_ready, chk_row: chk_sel};

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////
    // no back-pressure on fetch_a, a new strobe must wait for fetch_a_ready
    a_fetch_overlap: assert property (@(posedge clk) disable iff (!arst_n)
        (gen_en && fetch_a) |-> !(s1_vld || s2_vld))
        else $error("fetch_a while an A fetch is in flight");

endmodule

// ==== logic/chk_pkg.sv ====
package chk_pkg;

    //////////////////////////////////////////////////////////////////////
    // default sizes, overridden from the top level
    //////////////////////////////////////////////////////////////////////
    parameter int DEF_N_DIM  = 32;  // rows per matrix, elements per row
    parameter int DEF_DATA_W = 32;  // element width

    //////////////////////////////////////////////////////////////////////
    // operating mode and pass flags
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        MODE_IDLE   = 2'd0,
        MODE_DETECT = 2'd1,     // normal compute with error detection
        MODE_CORR1  = 2'd2,     // correction, first recompute
        MODE_CORR2  = 2'd3      // correction, second recompute
    } mode_e;

    // one-hot pass-complete flag
    typedef logic [2:0] full_t;

    parameter full_t FULL_DETECT = 3'b001;
    parameter full_t FULL_CORR1  = 3'b010;
    parameter full_t FULL_CORR2  = 3'b100;

    //////////////////////////////////////////////////////////////////////
    // control and event bundles between the units
    //////////////////////////////////////////////////////////////////////
    // from mode_ctrl to both checksum units
    typedef struct packed {
        logic restart_rows;     // zero the row counters
        logic clear_sums;       // zero stored checksums, mark not built
    } ctrl_t;

    // from col_checksum_a back to mode_ctrl
    typedef struct packed {
        logic row_done;         // fetch finished, same cycle as fetch_a_ready
        logic chk_row;          // the finished fetch returned the checksum row
    } a_evt_t;

endpackage
